//--- verilog/rv32i_pkg.sv
`default_nettype none

package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_idx_t;

    // base opcodes of the kept subset
    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_t;

    // same encoding as funct3 of the branches
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_t;

    typedef enum logic {op_a_rs1, op_a_pc} op_a_sel_t;
    typedef enum logic {op_b_rs2, op_b_imm} op_b_sel_t;
    typedef enum logic [1:0] {wb_alu, wb_pc_plus4, wb_load, wb_cmp} wb_sel_t;
    typedef enum logic [1:0] {fwd_regfile, fwd_mem_alu, fwd_wb_value} fwd_sel_t;

    typedef struct packed {
        reg_idx_t  rs1;          // zero when the format has no rs1
        reg_idx_t  rs2;
        reg_idx_t  rd;
        alu_op_t   alu_op;
        cmp_op_t   cmp_op;
        op_a_sel_t op_a_sel;
        op_b_sel_t op_b_sel;
        wb_sel_t   wb_sel;
        word_t     imm;          // already sign extended
        logic      is_branch;
        logic      is_jal;
        logic      is_jalr;
        logic      mem_read;
        logic      mem_write;
        logic      mem_byte;     // lb/lbu/sb, else word
        logic      load_unsigned;
        logic      reg_write;
        opcode_t   opcode;
    } ctrl_word_t;

    // bubble, decodes like addi x0, x0, 0 with all enables off
    localparam ctrl_word_t CTRL_NOP = '{
        rs1: '0, rs2: '0, rd: '0,
        alu_op: alu_add, cmp_op: cmp_beq,
        op_a_sel: op_a_rs1, op_b_sel: op_b_imm, wb_sel: wb_alu,
        imm: '0,
        is_branch: 1'b0, is_jal: 1'b0, is_jalr: 1'b0,
        mem_read: 1'b0, mem_write: 1'b0, mem_byte: 1'b0,
        load_unsigned: 1'b0, reg_write: 1'b0,
        opcode: op_imm
    };

endpackage

`default_nettype wire

//--- verilog/rv32i_control.sv
`default_nettype none

module rv32i_control (
    input  rv32i_pkg::word_t      instr,
    output rv32i_pkg::ctrl_word_t ctrl
);
    import rv32i_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      j_imm;
    ctrl_word_t dec;
    logic       valid;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign i_imm = {{21{instr[31]}}, instr[30:20]};
    assign s_imm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
    assign b_imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign u_imm = {instr[31:12], 12'h000};
    assign j_imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to alu function, alt picks sub / sra
    function automatic alu_op_t arith_op(input logic [2:0] f3, input logic alt);
        alu_op_t op;
        case (f3)
            3'b000:  op = alt ? alu_sub : alu_add;
            3'b001:  op = alu_sll;
            3'b010:  op = alu_slt;
            3'b011:  op = alu_sltu;
            3'b100:  op = alu_xor;
            3'b101:  op = alt ? alu_sra : alu_srl;
            3'b110:  op = alu_or;
            default: op = alu_and;
        endcase
        return op;
    endfunction

    always_comb begin
        dec        = CTRL_NOP;
        dec.rd     = instr[11:7];
        dec.opcode = opcode_t'(instr[6:0]);
        valid      = 1'b1;
        case (instr[6:0])
            op_lui: begin
                dec.imm       = u_imm; // rs1 stays x0, so alu gives 0 + imm
                dec.reg_write = 1'b1;
            end
            op_auipc: begin
                dec.imm       = u_imm;
                dec.op_a_sel  = op_a_pc;
                dec.reg_write = 1'b1;
            end
            op_jal: begin
                dec.imm       = j_imm;
                dec.is_jal    = 1'b1;
                dec.wb_sel    = wb_pc_plus4;
                dec.reg_write = 1'b1;
            end
            op_jalr: begin
                dec.rs1       = instr[19:15];
                dec.imm       = i_imm;
                dec.is_jalr   = 1'b1;
                dec.wb_sel    = wb_pc_plus4;
                dec.reg_write = 1'b1;
            end
            op_br: begin
                dec.rs1       = instr[19:15];
                dec.rs2       = instr[24:20];
                dec.imm       = b_imm;
                dec.op_b_sel  = op_b_rs2;  // comparator sees rs1 vs rs2
                dec.cmp_op    = cmp_op_t'(funct3);
                dec.is_branch = 1'b1;
                valid         = funct3[2:1] != 2'b01;
            end
            op_load: begin
                dec.rs1           = instr[19:15];
                dec.imm           = i_imm;
                dec.mem_read      = 1'b1;
                dec.mem_byte      = funct3[1:0] == 2'b00;
                dec.load_unsigned = funct3[2];
                dec.wb_sel        = wb_load;
                dec.reg_write     = 1'b1;
                valid = funct3 == 3'b000 || funct3 == 3'b010 || funct3 == 3'b100;
            end
            op_store: begin
                dec.rs1       = instr[19:15];
                dec.rs2       = instr[24:20];
                dec.imm       = s_imm;
                dec.mem_write = 1'b1;
                dec.mem_byte  = funct3 == 3'b000;
                valid         = funct3 == 3'b000 || funct3 == 3'b010;
            end
            op_imm: begin
                dec.rs1       = instr[19:15];
                dec.imm       = i_imm;
                dec.alu_op    = arith_op(funct3, funct3 == 3'b101 && funct7[5]);
                dec.reg_write = 1'b1;
            end
            op_reg: begin
                dec.rs1       = instr[19:15];
                dec.rs2       = instr[24:20];
                dec.op_b_sel  = op_b_rs2;
                dec.alu_op    = arith_op(funct3, funct7[5]);
                dec.reg_write = 1'b1;
            end
            default: valid = 1'b0;
        endcase
        ctrl = valid ? dec : CTRL_NOP;
    end

endmodule

`default_nettype wire

//--- verilog/rv32i_regfile.sv
`default_nettype none

module rv32i_regfile (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  rv32i_pkg::reg_idx_t waddr,
    input  rv32i_pkg::word_t    wdata,
    input  rv32i_pkg::reg_idx_t raddr_a,
    input  rv32i_pkg::reg_idx_t raddr_b,
    output rv32i_pkg::word_t    rdata_a,
    output rv32i_pkg::word_t    rdata_b
);
    import rv32i_pkg::*;

    word_t regs [1:31]; // x0 has no storage

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    function automatic word_t read_port(input reg_idx_t idx);
        word_t val;
        if (idx == '0) begin
            val = '0;
        end else if (we && waddr == idx) begin
            val = wdata; // write in flight, hand it straight to ID
        end else begin
            val = regs[idx];
        end
        return val;
    endfunction

    always_comb begin
        rdata_a = read_port(raddr_a);
        rdata_b = read_port(raddr_b);
    end

endmodule

`default_nettype wire

//--- verilog/rv32i_alu.sv
`default_nettype none

module rv32i_alu (
    input  rv32i_pkg::alu_op_t alu_op,
    input  rv32i_pkg::cmp_op_t cmp_op,
    input  rv32i_pkg::word_t   a,
    input  rv32i_pkg::word_t   b,
    output rv32i_pkg::word_t   result,
    output logic               cmp_true
);
    import rv32i_pkg::*;

    logic       eq;
    logic       lt;
    logic       ltu;
    logic [4:0] shamt;

    assign eq    = a == b;
    assign lt    = $signed(a) < $signed(b);
    assign ltu   = a < b;
    assign shamt = b[4:0];

    always_comb begin
        case (alu_op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_slt:  result = {31'b0, lt};  // shares the branch comparators
            alu_sltu: result = {31'b0, ltu};
            alu_xor:  result = a ^ b;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = word_t'($signed(a) >>> shamt);
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = a + b;
        endcase
    end

    always_comb begin
        case (cmp_op)
            cmp_beq:  cmp_true = eq;
            cmp_bne:  cmp_true = !eq;
            cmp_blt:  cmp_true = lt;
            cmp_bge:  cmp_true = !lt;
            cmp_bltu: cmp_true = ltu;
            cmp_bgeu: cmp_true = !ltu;
            default:  cmp_true = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/rv32i_hazard.sv
`default_nettype none

module rv32i_hazard (
    input  rv32i_pkg::ctrl_word_t id_ctrl,
    input  rv32i_pkg::ctrl_word_t ex_ctrl,
    input  rv32i_pkg::ctrl_word_t mem_ctrl,
    input  rv32i_pkg::ctrl_word_t wb_ctrl,
    output rv32i_pkg::fwd_sel_t   fwd_a,
    output rv32i_pkg::fwd_sel_t   fwd_b,
    output logic                  load_use_stall
);
    import rv32i_pkg::*;

    logic rs1_dep;
    logic rs2_dep;

    // youngest producer wins, x0 never forwards
    function automatic fwd_sel_t pick_source(
        input reg_idx_t   rs,
        input ctrl_word_t mem_c,
        input ctrl_word_t wb_c
    );
        fwd_sel_t sel;
        if (rs == '0) begin
            sel = fwd_regfile;
        end else if (mem_c.reg_write && mem_c.rd == rs) begin
            sel = fwd_mem_alu;
        end else if (wb_c.reg_write && wb_c.rd == rs) begin
            sel = fwd_wb_value;
        end else begin
            sel = fwd_regfile;
        end
        return sel;
    endfunction

    assign fwd_a = pick_source(ex_ctrl.rs1, mem_ctrl, wb_ctrl);
    assign fwd_b = pick_source(ex_ctrl.rs2, mem_ctrl, wb_ctrl);

    // load result not ready until WB, so a consumer right behind it waits one cycle
    assign rs1_dep = id_ctrl.rs1 != '0 && id_ctrl.rs1 == ex_ctrl.rd;
    assign rs2_dep = id_ctrl.rs2 != '0 && id_ctrl.rs2 == ex_ctrl.rd;

    assign load_use_stall = ex_ctrl.mem_read && (rs1_dep || rs2_dep);

endmodule

`default_nettype wire

//--- verilog/rv32i_lsu_align.sv
`default_nettype none

module rv32i_lsu_align (
    input  rv32i_pkg::ctrl_word_t mem_ctrl,
    input  rv32i_pkg::ctrl_word_t wb_ctrl,
    input  logic [1:0]            addr_lo,
    input  logic [1:0]            wb_addr_lo,
    input  rv32i_pkg::word_t      store_data,
    input  rv32i_pkg::word_t      load_word,
    output rv32i_pkg::word_t      wdata,
    output logic [3:0]            mbe,
    output rv32i_pkg::word_t      load_value
);
    import rv32i_pkg::*;

    logic [7:0] load_byte;

    // store side, MEM stage
    always_comb begin
        if (mem_ctrl.mem_byte) begin
            wdata = {4{store_data[7:0]}}; // byte on every lane, mbe picks one
            mbe   = 4'b0001 << addr_lo;
        end else begin
            wdata = store_data;
            mbe   = 4'b1111;
        end
        if (!mem_ctrl.mem_write) begin
            mbe = 4'b0000;
        end
    end

    // load side, WB stage
    assign load_byte = load_word[{wb_addr_lo, 3'b000} +: 8];

    always_comb begin
        if (!wb_ctrl.mem_byte) begin
            load_value = load_word;
        end else if (wb_ctrl.load_unsigned) begin
            load_value = {24'b0, load_byte};
        end else begin
            load_value = {{24{load_byte[7]}}, load_byte};
        end
    end

endmodule

`default_nettype wire

//--- verilog/rv32i_core.sv
`default_nettype none

module rv32i_core #(
    parameter rv32i_pkg::word_t RESET_PC = '0
) (
    input  logic             clk,
    input  logic             rst_n,
    input  rv32i_pkg::word_t inst_rdata,
    input  logic             inst_resp,
    output rv32i_pkg::word_t inst_addr,
    output logic             inst_read,
    input  rv32i_pkg::word_t data_rdata,
    input  logic             data_resp,
    output rv32i_pkg::word_t data_addr,
    output rv32i_pkg::word_t data_wdata,
    output logic [3:0]       data_mbe,
    output logic             data_read,
    output logic             data_write
);
    import rv32i_pkg::*;

    logic       advance;
    logic       load_use_stall;
    logic       redirect;
    logic       stall;
    word_t      pc;
    word_t      pc_id;
    word_t      ir_id;
    ctrl_word_t id_ctrl;
    word_t      rs1_data;
    word_t      rs2_data;
    ctrl_word_t ex_ctrl;
    word_t      pc_ex;
    word_t      rs1_ex;
    word_t      rs2_ex;
    fwd_sel_t   fwd_a;
    fwd_sel_t   fwd_b;
    word_t      rs1_fwd;
    word_t      rs2_fwd;
    word_t      op_a;
    word_t      op_b;
    word_t      alu_result;
    logic       cmp_ex;
    word_t      target_ex;
    ctrl_word_t mem_ctrl;
    word_t      pc_mem;
    word_t      alu_mem;
    word_t      store_mem;
    word_t      target_mem;
    logic       cmp_mem;
    ctrl_word_t wb_ctrl;
    word_t      pc_wb;
    word_t      alu_wb;
    word_t      load_wb;
    word_t      load_value;
    word_t      wb_value;

    function automatic word_t fwd_mux(
        input fwd_sel_t sel,
        input word_t    rf_val,
        input word_t    mem_val,
        input word_t    wb_val
    );
        word_t val;
        case (sel)
            fwd_mem_alu:  val = mem_val;
            fwd_wb_value: val = wb_val;
            default:      val = rf_val;
        endcase
        return val;
    endfunction

    // whole pipe freezes while either memory is still busy
    assign advance  = inst_resp && (!(data_read || data_write) || data_resp);
    assign redirect = mem_ctrl.is_jal || mem_ctrl.is_jalr || (mem_ctrl.is_branch && cmp_mem);
    assign stall    = load_use_stall && !redirect; // redirect squashes the stalled pair anyway

    assign inst_read = 1'b1;
    assign inst_addr = pc;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc    <= RESET_PC;
            ir_id <= '0;
        end else if (advance) begin
            if (redirect) begin
                pc    <= target_mem;
                ir_id <= '0; // zero word decodes to a bubble
            end else if (!stall) begin
                pc    <= pc + 32'd4;
                ir_id <= inst_rdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (advance && !stall) begin
            pc_id <= pc;
        end
    end

    rv32i_control u_control (.instr(ir_id), .ctrl(id_ctrl));

    rv32i_regfile u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .we      (wb_ctrl.reg_write && advance),
        .waddr   (wb_ctrl.rd),
        .wdata   (wb_value),
        .raddr_a (id_ctrl.rs1),
        .raddr_b (id_ctrl.rs2),
        .rdata_a (rs1_data),
        .rdata_b (rs2_data)
    );

    rv32i_hazard u_hazard (
        .id_ctrl        (id_ctrl),
        .ex_ctrl        (ex_ctrl),
        .mem_ctrl       (mem_ctrl),
        .wb_ctrl        (wb_ctrl),
        .fwd_a          (fwd_a),
        .fwd_b          (fwd_b),
        .load_use_stall (load_use_stall)
    );

    // bubbles enter on stall or redirect
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_ctrl  <= CTRL_NOP;
            mem_ctrl <= CTRL_NOP;
            wb_ctrl  <= CTRL_NOP;
        end else if (advance) begin
            ex_ctrl  <= (redirect || stall) ? CTRL_NOP : id_ctrl;
            mem_ctrl <= redirect ? CTRL_NOP : ex_ctrl;
            wb_ctrl  <= mem_ctrl;
        end
    end

    always_comb begin
        rs1_fwd = fwd_mux(fwd_a, rs1_ex, alu_mem, wb_value);
        rs2_fwd = fwd_mux(fwd_b, rs2_ex, alu_mem, wb_value);
    end

    assign op_a = (ex_ctrl.op_a_sel == op_a_pc) ? pc_ex : rs1_fwd;
    assign op_b = (ex_ctrl.op_b_sel == op_b_imm) ? ex_ctrl.imm : rs2_fwd;

    rv32i_alu u_alu (
        .alu_op   (ex_ctrl.alu_op),
        .cmp_op   (ex_ctrl.cmp_op),
        .a        (op_a),
        .b        (op_b),
        .result   (alu_result),
        .cmp_true (cmp_ex)
    );

    assign target_ex = ex_ctrl.is_jalr ? {alu_result[31:1], 1'b0} : pc_ex + ex_ctrl.imm;

    // datapath registers
    always_ff @(posedge clk) begin
        if (advance) begin
            pc_ex      <= pc_id;
            rs1_ex     <= rs1_data;
            rs2_ex     <= rs2_data;
            pc_mem     <= pc_ex;
            alu_mem    <= alu_result;
            store_mem  <= rs2_fwd;
            target_mem <= target_ex;
            cmp_mem    <= cmp_ex;
            pc_wb      <= pc_mem;
            alu_wb     <= alu_mem;
            load_wb    <= data_rdata; // valid on the advancing cycle of a load
        end
    end

    assign data_read  = mem_ctrl.mem_read;
    assign data_write = mem_ctrl.mem_write;
    assign data_addr  = alu_mem;

    rv32i_lsu_align u_lsu_align (
        .mem_ctrl   (mem_ctrl),
        .wb_ctrl    (wb_ctrl),
        .addr_lo    (alu_mem[1:0]),
        .wb_addr_lo (alu_wb[1:0]),
        .store_data (store_mem),
        .load_word  (load_wb),
        .wdata      (data_wdata),
        .mbe        (data_mbe),
        .load_value (load_value)
    );

    always_comb begin
        case (wb_ctrl.wb_sel)
            wb_pc_plus4: wb_value = pc_wb + 32'd4;  // link address
            wb_load:     wb_value = load_value;
            default:     wb_value = alu_wb;
        endcase
    end

endmodule

`default_nettype wire

//--- test/rv32i_core_chk.sv
`default_nettype none

module rv32i_core_chk (
    input logic             clk,
    input logic             rst_n,
    input logic             data_read,
    input logic             data_write,
    input logic             data_resp,
    input rv32i_pkg::word_t data_addr
);

    int unsigned error_count = 0;

    // a MEM-stage instruction is either a load or a store
    a_read_write_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(data_read && data_write))
        else begin
            error_count++;
            $error("data_read and data_write high together");
        end

    a_idle_after_reset: assert property (@(posedge clk)
        $rose(rst_n) |-> (!data_read && !data_write))
        else begin
            error_count++;
            $error("data port active right after reset");
        end

    // address holds until the memory answers
    a_addr_stable: assert property (@(posedge clk) disable iff (!rst_n)
        ((data_read || data_write) && !data_resp) |=> $stable(data_addr))
        else begin
            error_count++;
            $error("data_addr changed while waiting for data_resp");
        end

endmodule

bind rv32i_core rv32i_core_chk u_chk (.*);

`default_nettype wire

//--- test/rv32i_core_tb.sv
`default_nettype none

module rv32i_core_tb;
    import rv32i_pkg::*;

    localparam int MARKER_WORD = 63; // byte address 0xfc

    logic  clk;
    logic  rst_n;
    word_t inst_rdata;
    logic  inst_resp;
    word_t inst_addr;
    logic  inst_read;
    word_t data_rdata;
    logic  data_resp;
    word_t data_addr;
    word_t data_wdata;
    logic [3:0] data_mbe;
    logic  data_read;
    logic  data_write;

    word_t       imem [0:255];
    word_t       dmem [0:63];
    int          prog_len;
    logic [31:0] lcg_state;
    bit          random_delays;
    bit          new_req;
    int          icnt;
    int          dcnt;
    int          byte_writes;
    logic        adv;
    word_t       alu_exp [1:14];

    rv32i_core #(.RESET_PC(32'h0)) u_rv32i_core (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic fail(input string msg);
        $display("ERROR at time %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "stopping after first error");
    endtask

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic int pick_delay();
        if (!random_delays) return 0;
        return (next_random() >> 13) % 4;
    endfunction

    // memory models drive their inputs on the falling edge
    always @(negedge clk) begin
        if (!rst_n) begin
            new_req   = 1'b1;
            inst_resp = 1'b0;
            data_resp = 1'b0;
        end else begin
            if (new_req) begin
                icnt    = pick_delay();
                dcnt    = pick_delay();
                new_req = 1'b0;
            end
            inst_resp  = icnt == 0;
            inst_rdata = imem[inst_addr[9:2]];
            if (icnt > 0) icnt--;
            if (data_read || data_write) begin
                data_resp = dcnt == 0;
                if (dcnt > 0) dcnt--;
            end else begin
                data_resp = 1'b0;
            end
            data_rdata = dmem[data_addr[7:2]];
        end
    end

    always @(posedge clk) begin
        if (rst_n) begin
            assert (inst_read)
                else fail("inst_read low outside reset");
            adv = inst_resp && (!(data_read || data_write) || data_resp);
            if (adv) new_req = 1'b1; // next cycle is a fresh request
            if (adv && data_write) begin
                assert (data_mbe == 4'hf || data_mbe == (4'b0001 << data_addr[1:0]))
                    else fail($sformatf("data_mbe %b wrong for address %h", data_mbe, data_addr));
                if (data_mbe != 4'hf) byte_writes++;
                for (int i = 0; i < 4; i++) begin
                    if (data_mbe[i]) dmem[data_addr[7:2]][8*i +: 8] = data_wdata[8*i +: 8];
                end
            end
        end
    end

    // a failing protocol assertion in the bound checker ends the run
    always @(negedge clk) begin
        if (u_rv32i_core.u_chk.error_count != 0) begin
            fail("the data port checker flagged a protocol violation");
        end
    end

    function automatic word_t r_type(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3, logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t i_type(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                     logic [4:0] rd, logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t s_type(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t b_type(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
    endfunction

    function automatic word_t j_type(logic [20:0] imm, logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
    endfunction

    task automatic emit(input word_t w);
        imem[prog_len] = w;
        prog_len++;
    endtask

    task automatic addi(input int rd, input int rs1, input int imm);
        emit(i_type(imm, rs1, 3'b000, rd, 7'b0010011));
    endtask

    task automatic sw(input int rs2, input int offset);
        emit(s_type(offset, rs2, 5'd0, 3'b010));
    endtask

    task automatic clear_memories();
        for (int i = 0; i < 256; i++) imem[i] = '0; // zero decodes as a bubble
        for (int i = 0; i < 64; i++) dmem[i] = '0;
        prog_len    = 0;
        byte_writes = 0;
    endtask

    // append the marker store and wait for it after reset
    task automatic execute_program();
        int cycles;
        addi(31, 0, 1);
        sw(31, 4 * MARKER_WORD);
        rst_n = 1'b0;
        repeat (16) @(negedge clk);
        rst_n  = 1'b1;
        cycles = 0;
        while (dmem[MARKER_WORD] !== 32'h1) begin
            @(negedge clk);
            cycles++;
            if (cycles > 3000) fail("timeout waiting for the marker store");
        end
    endtask

    task automatic expect_word(input int addr, input word_t exp, input string what);
        assert (dmem[addr >> 2] === exp)
            else fail($sformatf("%s at %h: got %h expected %h", what, addr,
                                dmem[addr >> 2], exp));
    endtask

    task automatic alu_program();
        int auipc_pc;
        clear_memories();
        emit({20'h12345, 5'd1, 7'b0110111});            // lui x1
        addi(1, 1, 12'h678);
        addi(2, 0, -5);
        emit(r_type(7'h00, 2, 1, 3'b000, 3));           // add
        emit(r_type(7'h20, 1, 3, 3'b000, 4));           // sub
        emit(r_type(7'h00, 3, 4, 3'b100, 5));           // xor
        emit(r_type(7'h00, 2, 5, 3'b110, 6));           // or
        emit(r_type(7'h00, 1, 6, 3'b111, 7));           // and
        emit(i_type(12'd4, 1, 3'b001, 8, 7'b0010011));  // slli
        emit(i_type(12'h401, 2, 3'b101, 9, 7'b0010011)); // srai
        emit(i_type(12'd28, 2, 3'b101, 10, 7'b0010011)); // srli
        emit(r_type(7'h00, 1, 2, 3'b010, 11));          // slt
        emit(r_type(7'h00, 1, 2, 3'b011, 12));          // sltu
        auipc_pc = prog_len * 4;
        emit({20'h00001, 5'd13, 7'b0010111});           // auipc
        emit(r_type(7'h20, 10, 1, 3'b101, 14));         // sra
        for (int i = 1; i <= 14; i++) sw(i, 4 * (i - 1));
        alu_exp[1]  = 32'h12345000 + 32'h678;
        alu_exp[2]  = -32'sd5;
        alu_exp[3]  = alu_exp[1] + alu_exp[2];
        alu_exp[4]  = alu_exp[3] - alu_exp[1];
        alu_exp[5]  = alu_exp[4] ^ alu_exp[3];
        alu_exp[6]  = alu_exp[5] | alu_exp[2];
        alu_exp[7]  = alu_exp[6] & alu_exp[1];
        alu_exp[8]  = alu_exp[1] << 4;
        alu_exp[9]  = $signed(alu_exp[2]) >>> 1;
        alu_exp[10] = alu_exp[2] >> 28;
        alu_exp[11] = ($signed(alu_exp[2]) < $signed(alu_exp[1])) ? 1 : 0;
        alu_exp[12] = (alu_exp[2] < alu_exp[1]) ? 1 : 0;
        alu_exp[13] = auipc_pc + 32'h1000;
        alu_exp[14] = $signed(alu_exp[1]) >>> alu_exp[10][4:0];
        execute_program();
        for (int i = 1; i <= 14; i++) begin
            expect_word(4 * (i - 1), alu_exp[i], $sformatf("alu result x%0d", i));
        end
    endtask

    task automatic load_use_program();
        word_t v;
        clear_memories();
        v = -32'sd100;
        addi(1, 0, -100);
        sw(1, 12'h40);
        emit(i_type(12'h40, 0, 3'b010, 2, 7'b0000011)); // lw used right away
        addi(3, 2, 7);
        sw(3, 12'h44);
        emit(i_type(12'h40, 0, 3'b000, 4, 7'b0000011)); // lb
        sw(4, 12'h48);
        emit(i_type(12'h40, 0, 3'b100, 5, 7'b0000011)); // lbu
        emit(r_type(7'h00, 0, 5, 3'b000, 6));
        sw(6, 12'h4c);
        emit(i_type(12'h41, 0, 3'b000, 7, 7'b0000011)); // lb of an upper lane
        sw(7, 12'h50);
        execute_program();
        expect_word(12'h44, v + 7, "lw use");
        expect_word(12'h48, {{24{v[7]}}, v[7:0]}, "lb sign extension");
        expect_word(12'h4c, {24'b0, v[7:0]}, "lbu zero extension");
        expect_word(12'h50, {{24{v[15]}}, v[15:8]}, "lb lane 1");
    endtask

    task automatic byte_store_program();
        clear_memories();
        addi(1, 0, 12'h11);
        emit(s_type(12'h80, 1, 0, 3'b000));
        addi(1, 0, 12'h22);
        emit(s_type(12'h81, 1, 0, 3'b000));
        addi(1, 0, 12'h33);
        emit(s_type(12'h82, 1, 0, 3'b000));
        addi(1, 0, 12'h1a5); // only the low byte lands
        emit(s_type(12'h83, 1, 0, 3'b000));
        execute_program();
        expect_word(12'h80, 32'ha5332211, "assembled bytes");
        assert (byte_writes == 4)
            else fail($sformatf("expected 4 single-lane writes, saw %0d", byte_writes));
    endtask

    task automatic branch_program();
        clear_memories();
        addi(1, 0, 5);
        addi(2, 0, 5);
        addi(3, 0, -1);
        addi(9, 0, 12'h5a5);                            // poison
        addi(10, 0, 12'h77);
        emit(b_type(12, 2, 1, 3'b000));                 // beq taken
        sw(9, 12'ha0);
        sw(9, 12'ha0);
        emit(b_type(8, 2, 1, 3'b001));                  // bne not taken
        sw(10, 12'ha4);
        emit(b_type(12, 1, 3, 3'b100));                 // blt taken
        sw(9, 12'ha0);
        sw(9, 12'ha0);
        emit(b_type(12, 1, 3, 3'b111));                 // bgeu taken
        sw(9, 12'ha0);
        sw(9, 12'ha0);
        emit(b_type(8, 3, 1, 3'b100));                  // blt not taken
        sw(10, 12'ha8);
        emit(b_type(8, 3, 1, 3'b001));                  // bne taken
        sw(9, 12'ha0);
        emit(b_type(8, 3, 1, 3'b000));                  // beq not taken
        sw(10, 12'hac);
        emit(b_type(8, 3, 1, 3'b111));                  // bgeu not taken
        sw(10, 12'hb0);
        execute_program();
        expect_word(12'ha0, 32'h0, "poison after taken branch");
        expect_word(12'ha4, 32'h77, "bne not taken path");
        expect_word(12'ha8, 32'h77, "blt not taken path");
        expect_word(12'hac, 32'h77, "beq not taken path");
        expect_word(12'hb0, 32'h77, "bgeu not taken path");
    endtask

    task automatic jump_program();
        word_t jal_link;
        word_t jalr_link;
        clear_memories();
        addi(9, 0, 12'h5a5);
        addi(10, 0, 12'h33);
        jal_link = prog_len * 4 + 4;
        emit(j_type(12, 1));                            // jal over two poison stores
        sw(9, 12'hc0);
        sw(9, 12'hc0);
        sw(1, 12'hc4);
        sw(10, 12'hc8);
        addi(5, 0, (prog_len + 4) * 4);
        jalr_link = prog_len * 4 + 4;
        emit(i_type(12'd1, 5, 3'b000, 6, 7'b1100111)); // jalr with target bit 0 dropped
        sw(9, 12'hc0);
        sw(9, 12'hc0);
        sw(6, 12'hcc);
        addi(11, 0, 12'h44);
        sw(11, 12'hd0);
        execute_program();
        expect_word(12'hc0, 32'h0, "poison after jump");
        expect_word(12'hc4, jal_link, "jal link");
        expect_word(12'hc8, 32'h33, "jal target code");
        expect_word(12'hcc, jalr_link, "jalr link");
        expect_word(12'hd0, 32'h44, "jalr target code");
    endtask

    initial begin
        rst_n         = 1'b0;
        inst_rdata    = '0;
        inst_resp     = 1'b0;
        data_rdata    = '0;
        data_resp     = 1'b0;
        lcg_state     = 32'h7610;
        random_delays = 1'b0;
        new_req       = 1'b1;
        icnt          = 0;
        dcnt          = 0;
        alu_program();
        load_use_program();
        byte_store_program();
        branch_program();
        jump_program();
        random_delays = 1'b1; // same program under back-pressure
        alu_program();
        if (u_rv32i_core.u_chk.error_count == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            fail("the data port checker flagged a protocol violation");
        end
    end

endmodule

`default_nettype wire

//--- verilog.f
verilog/rv32i_pkg.sv
verilog/rv32i_control.sv
verilog/rv32i_regfile.sv
verilog/rv32i_alu.sv
verilog/rv32i_hazard.sv
verilog/rv32i_lsu_align.sv
verilog/rv32i_core.sv
test/rv32i_core_chk.sv
test/rv32i_core_tb.sv

//--- Bender.yml
package:
  name: rv32i_core

sources:
  - verilog/rv32i_pkg.sv
  - verilog/rv32i_control.sv
  - verilog/rv32i_regfile.sv
  - verilog/rv32i_alu.sv
  - verilog/rv32i_hazard.sv
  - verilog/rv32i_lsu_align.sv
  - verilog/rv32i_core.sv
  - target: test
    files:
      - test/rv32i_core_chk.sv
      - test/rv32i_core_tb.sv
